/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= iq_tb
FILELIST ?= filelist.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+include
hw/iq_pkg.sv
hw/iq_ctrl.sv
hw/iq_storage.sv
hw/iq_read_mux.sv
hw/iq_delay_slot.sv
hw/iq_issue_stats.sv
hw/inst_queue_top.sv
verif/iq_tb.sv

/* hw/inst_queue_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "iq_settings.svh"

module inst_queue_top (
    input  wire logic                 clk,
    input  wire logic                 fifo_rst,
    input  wire iq_pkg::iq_wr_pkt_t   wr_pkt,
    input  wire logic                 issue0,
    input  wire logic                 issue1,
    input  wire logic                 flush,
    input  wire logic                 keep_slot,
    output iq_pkg::iq_rd_pkt_t        rd_pkt,
    output logic                      full,
    output logic                      in_delay_slot,
    output iq_pkg::iq_stats_t         stats
);

    iq_pkg::iq_take_t     take;
    iq_pkg::iq_hold_e     hold_state;
    iq_pkg::iq_entry_t    held;
    iq_pkg::iq_entry_t    head0;
    iq_pkg::iq_entry_t    head1;
    logic [`IQ_PTR_W-1:0] wr_ptr;
    logic [`IQ_PTR_W-1:0] rd_ptr;
    logic [1:0]           avail;

    iq_ctrl u_ctrl (
        .clk        (clk),
        .fifo_rst   (fifo_rst),
        .wr_pkt     (wr_pkt),
        .issue0     (issue0),
        .issue1     (issue1),
        .flush      (flush),
        .hold_state (hold_state),
        .take       (take),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr),
        .avail      (avail),
        .full       (full)
    );

    iq_storage u_storage (
        .clk    (clk),
        .wr_pkt (wr_pkt),
        .wr_ptr (wr_ptr),
        .rd_ptr (rd_ptr),
        .head0  (head0),
        .head1  (head1)
    );

    iq_read_mux u_read_mux (
        .avail      (avail),
        .hold_state (hold_state),
        .held       (held),
        .head0      (head0),
        .head1      (head1),
        .rd_pkt     (rd_pkt)
    );

    iq_delay_slot u_delay_slot (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .flush         (flush),
        .keep_slot     (keep_slot),
        .take          (take),
        .rd_pkt        (rd_pkt),
        .hold_state    (hold_state),
        .held          (held),
        .in_delay_slot (in_delay_slot)
    );

    iq_issue_stats u_issue_stats (
        .clk      (clk),
        .fifo_rst (fifo_rst),
        .take     (take),
        .stats    (stats)
    );

endmodule

`default_nettype wire

/* hw/iq_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "iq_settings.svh"

module iq_ctrl (
    input  wire logic                 clk,
    input  wire logic                 fifo_rst,
    input  wire iq_pkg::iq_wr_pkt_t   wr_pkt,
    input  wire logic                 issue0,
    input  wire logic                 issue1,
    input  wire logic                 flush,
    input  wire iq_pkg::iq_hold_e     hold_state,
    output iq_pkg::iq_take_t          take,
    output logic [`IQ_PTR_W-1:0]      wr_ptr,
    output logic [`IQ_PTR_W-1:0]      rd_ptr,
    output logic [1:0]                avail,
    output logic                      full
);

    localparam int PTR_W = `IQ_PTR_W;
    localparam int CNT_W = `IQ_PTR_W + 1;   // one extra bit so 16 fits
    localparam logic [CNT_W-1:0] FULL_LVL = CNT_W'(`IQ_DEPTH - 2);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] n_push;
    logic [CNT_W-1:0] n_pop;
    logic             holding;

    assign holding = (hold_state == iq_pkg::hold_valid);

    // entries presentable at the head
    always_comb begin
        if (count == '0)
            avail = 2'd0;
        else if (count == CNT_W'(1))
            avail = 2'd1;
        else
            avail = 2'd2;
    end

    // strobes on empty slots are dropped here
    // while an entry is held it is the only thing slot 0 can take
    always_comb begin
        take.taken0 = issue0 && (holding || (avail != 2'd0));
        take.taken1 = issue0 && issue1 && !holding && (avail == 2'd2);
    end

    assign n_push = CNT_W'(wr_pkt.valid0) + CNT_W'(wr_pkt.valid1);
    assign n_pop  = holding ? '0 : (CNT_W'(take.taken0) + CNT_W'(take.taken1));

    // room for one more pair is not guaranteed below two free entries
    assign full = (count >= FULL_LVL);

    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;   // same-cycle writes are lost
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_push);
            rd_ptr <= rd_ptr + PTR_W'(n_pop);
            count  <= count + n_push - n_pop;
        end
    end

    // fetch protocol
    property p_pair_order;
        @(posedge clk) disable iff (fifo_rst)
            wr_pkt.valid1 |-> wr_pkt.valid0;
    endproperty
    a_pair_order: assert property (p_pair_order)
        else $error("iq_ctrl: slot 1 written without slot 0");

    // upstream must watch full, the queue has no back-pressure
    property p_no_overflow;
        @(posedge clk) disable iff (fifo_rst)
            full |-> !wr_pkt.valid0;
    endproperty
    a_no_overflow: assert property (p_no_overflow)
        else $error("iq_ctrl: write while full");

    // issue protocol
    property p_issue_order;
        @(posedge clk) disable iff (fifo_rst)
            issue1 |-> issue0;
    endproperty
    a_issue_order: assert property (p_issue_order)
        else $error("iq_ctrl: issue1 without issue0");

endmodule

`default_nettype wire

/* hw/iq_delay_slot.sv */
`timescale 1ns/10ps
`default_nettype none

module iq_delay_slot (
    input  wire logic                 clk,
    input  wire logic                 fifo_rst,
    input  wire logic                 flush,
    input  wire logic                 keep_slot,
    input  wire iq_pkg::iq_take_t     take,
    input  wire iq_pkg::iq_rd_pkt_t   rd_pkt,
    output iq_pkg::iq_hold_e          hold_state,
    output iq_pkg::iq_entry_t         held,
    output logic                      in_delay_slot
);

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic             is_branch;
    logic             capture;
    iq_pkg::iq_hold_e hold_next;

    assign opcode = rd_pkt.entry0.instr[31:26];
    assign funct  = rd_pkt.entry0.instr[5:0];

    // branches and jumps, register jumps sit under special
    always_comb begin
        case (opcode)
            iq_pkg::op_special:
                is_branch = (funct == iq_pkg::fn_jr) || (funct == iq_pkg::fn_jalr);
            iq_pkg::op_regimm,
            iq_pkg::op_j,
            iq_pkg::op_jal,
            iq_pkg::op_beq,
            iq_pkg::op_bne,
            iq_pkg::op_blez,
            iq_pkg::op_bgtz:
                is_branch = 1'b1;
            default:
                is_branch = 1'b0;
        endcase
    end

    // next slot 0 is a delay slot only if the branch went out alone
    always_ff @(posedge clk) begin
        if (fifo_rst || flush)
            in_delay_slot <= 1'b0;
        else if (take.taken0)
            in_delay_slot <= is_branch && rd_pkt.valid0 && !take.taken1;
    end

    // keep the head across the flush, unless it is leaving this cycle
    assign capture = flush && keep_slot && !take.taken0 && rd_pkt.valid0;

    always_comb begin
        hold_next = hold_state;
        case (hold_state)
            iq_pkg::hold_empty:
                if (capture)
                    hold_next = iq_pkg::hold_valid;
            iq_pkg::hold_valid:
                if (take.taken0 || (flush && !capture))
                    hold_next = iq_pkg::hold_empty;
            default:
                hold_next = iq_pkg::hold_empty;
        endcase
    end

    always_ff @(posedge clk) begin
        if (fifo_rst)
            hold_state <= iq_pkg::hold_empty;
        else
            hold_state <= hold_next;
    end

    always_ff @(posedge clk) begin
        if (capture)
            held <= rd_pkt.entry0;
    end

endmodule

`default_nettype wire

/* hw/iq_issue_stats.sv */
`timescale 1ns/10ps
`default_nettype none

`include "iq_settings.svh"

module iq_issue_stats (
    input  wire logic                 clk,
    input  wire logic                 fifo_rst,
    input  wire iq_pkg::iq_take_t     take,
    output iq_pkg::iq_stats_t         stats
);

    localparam int STAT_W = `IQ_STAT_W;

    // flush does not reach here, counts span the whole run
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            stats <= '0;
        end else begin
            stats.count0 <= stats.count0 + STAT_W'(take.taken0);  // wraps
            stats.count1 <= stats.count1 + STAT_W'(take.taken1);
        end
    end

endmodule

`default_nettype wire

/* hw/iq_pkg.sv */
`default_nettype none

`include "iq_settings.svh"

package iq_pkg;

    // one fetched instruction with its address
    typedef struct packed {
        logic [`IQ_XLEN-1:0] pc;
        logic [`IQ_XLEN-1:0] instr;
    } iq_entry_t;

    // fetch side, valid1 only together with valid0
    typedef struct packed {
        logic      valid0;
        logic      valid1;
        iq_entry_t entry0;
        iq_entry_t entry1;
    } iq_wr_pkt_t;

    // issue side view of the head
    typedef struct packed {
        logic      valid0;
        logic      valid1;
        iq_entry_t entry0;
        iq_entry_t entry1;
    } iq_rd_pkt_t;

    typedef struct packed {
        logic taken0;
        logic taken1;
    } iq_take_t;

    typedef struct packed {
        logic [`IQ_STAT_W-1:0] count0;
        logic [`IQ_STAT_W-1:0] count1;
    } iq_stats_t;

    // primary opcodes, jr and jalr are funct codes under special
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07,
        fn_jr      = 6'h08,
        fn_jalr    = 6'h09
    } iq_opcode_e;

    typedef enum logic {
        hold_empty = 1'b0,
        hold_valid = 1'b1
    } iq_hold_e;

endpackage

`default_nettype wire

/* hw/iq_read_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module iq_read_mux (
    input  wire logic [1:0]           avail,
    input  wire iq_pkg::iq_hold_e     hold_state,
    input  wire iq_pkg::iq_entry_t    held,
    input  wire iq_pkg::iq_entry_t    head0,
    input  wire iq_pkg::iq_entry_t    head1,
    output iq_pkg::iq_rd_pkt_t        rd_pkt
);

    logic              vld0;
    logic              vld1;
    iq_pkg::iq_entry_t ent0;
    iq_pkg::iq_entry_t ent1;

    always_comb begin
        if (hold_state == iq_pkg::hold_valid) begin
            // held delay slot goes out alone
            vld0 = 1'b1;
            vld1 = 1'b0;
            ent0 = held;
            ent1 = '0;
        end else begin
            vld0 = (avail != 2'd0);
            vld1 = (avail == 2'd2);
            ent0 = vld0 ? head0 : '0;   // no stale array data on empty slots
            ent1 = vld1 ? head1 : '0;
        end
    end

    always_comb begin
        rd_pkt.valid0 = vld0;
        rd_pkt.valid1 = vld1;
        rd_pkt.entry0 = ent0;
        rd_pkt.entry1 = ent1;
    end

endmodule

`default_nettype wire

/* hw/iq_storage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "iq_settings.svh"

module iq_storage (
    input  wire logic                 clk,
    input  wire iq_pkg::iq_wr_pkt_t   wr_pkt,
    input  wire logic [`IQ_PTR_W-1:0] wr_ptr,
    input  wire logic [`IQ_PTR_W-1:0] rd_ptr,
    output iq_pkg::iq_entry_t         head0,
    output iq_pkg::iq_entry_t         head1
);

    localparam int PTR_W = `IQ_PTR_W;

    iq_pkg::iq_entry_t mem [`IQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr1;
    logic [PTR_W-1:0] rd_ptr1;

    // +1 wraps at depth since the pointer is exactly log2 wide
    assign wr_ptr1 = wr_ptr + PTR_W'(1);
    assign rd_ptr1 = rd_ptr + PTR_W'(1);

    // two write ports, adjacent entries
    always_ff @(posedge clk) begin
        if (wr_pkt.valid0)
            mem[wr_ptr] <= wr_pkt.entry0;
        if (wr_pkt.valid1)
            mem[wr_ptr1] <= wr_pkt.entry1;
    end

    // unqualified reads, the mux masks empty slots
    assign head0 = mem[rd_ptr];
    assign head1 = mem[rd_ptr1];

endmodule

`default_nettype wire

/* include/iq_settings.svh */
`ifndef IQ_SETTINGS_SVH
`define IQ_SETTINGS_SVH

// queue geometry
`define IQ_DEPTH 16
`define IQ_PTR_W 4   // log2 of depth, pointers wrap on their own

// payload widths
`define IQ_XLEN 32   // pc and instruction

// issue statistics
`define IQ_STAT_W 32 // counters wrap

`endif

/* verif/iq_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "iq_settings.svh"

module iq_tb;

    localparam int FULL_LEVEL  = `IQ_DEPTH - 2;
    localparam int STAT_W      = `IQ_STAT_W;
    localparam int DRAIN_LIMIT = 40;   // cycles, more than a full queue needs
    localparam int K_BEQ       = 0;
    localparam int K_J         = 1;
    localparam int K_JR        = 2;
    localparam int K_JALR      = 3;
    localparam int K_ADDI      = 4;
    localparam int K_LW        = 5;
    localparam int K_REGIMM    = 6;
    localparam int K_ADD       = 7;

    typedef struct packed {
        iq_pkg::iq_rd_pkt_t rd;
        logic               full;
        logic               ids;
    } expect_t;

    logic               clk;
    logic               fifo_rst;
    iq_pkg::iq_wr_pkt_t wr_pkt;
    logic               issue0;
    logic               issue1;
    logic               flush;
    logic               keep_slot;
    iq_pkg::iq_rd_pkt_t rd_pkt;
    logic               full;
    logic               in_delay_slot;
    iq_pkg::iq_stats_t  stats;

    // reference model
    iq_pkg::iq_entry_t  mq[$];
    logic               m_hold = 1'b0;
    iq_pkg::iq_entry_t  m_held = '0;
    logic               m_ids = 1'b0;
    logic [STAT_W-1:0]  m_cnt0 = '0;
    logic [STAT_W-1:0]  m_cnt1 = '0;

    integer             seed = 49;
    logic [31:0]        next_pc = 32'h0040_0000;
    int                 checks = 0;
    int                 errors = 0;
    int                 timeouts = 0;

    inst_queue_top dut0 (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .wr_pkt        (wr_pkt),
        .issue0        (issue0),
        .issue1        (issue1),
        .flush         (flush),
        .keep_slot     (keep_slot),
        .rd_pkt        (rd_pkt),
        .full          (full),
        .in_delay_slot (in_delay_slot),
        .stats         (stats)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // MIPS branch and jump rule
    function automatic logic is_branch(input logic [31:0] instr);
        logic [5:0] op;
        logic [5:0] fn;
        op = instr[31:26];
        fn = instr[5:0];
        if (op == 6'd0)
            return (fn == 6'h08) || (fn == 6'h09);   // jr, jalr
        return (op >= 6'd1) && (op <= 6'd7);
    endfunction

    function automatic logic [31:0] make_instr(input int kind);
        logic [31:0] r;
        logic [31:0] ins;
        r = $random(seed);
        case (kind)
            K_BEQ:    ins = {6'h04, r[25:0]};
            K_J:      ins = {6'h02, r[25:0]};
            K_JR:     ins = {6'h00, r[25:6], 6'h08};
            K_JALR:   ins = {6'h00, r[25:6], 6'h09};
            K_ADDI:   ins = {6'h08, r[25:0]};
            K_LW:     ins = {6'h23, r[25:0]};
            K_REGIMM: ins = {6'h01, r[25:0]};
            default:  ins = {6'h00, r[25:6], 6'h20};  // add
        endcase
        return ins;
    endfunction

    function automatic iq_pkg::iq_entry_t make_entry(input int kind);
        iq_pkg::iq_entry_t e;
        e.pc    = next_pc;
        e.instr = make_instr(kind);
        next_pc = next_pc + 32'd4;
        return e;
    endfunction

    function automatic iq_pkg::iq_wr_pkt_t pair_pkt(input int n, input int k0, input int k1);
        iq_pkg::iq_wr_pkt_t w;
        w = '0;
        if (n >= 1) begin
            w.valid0 = 1'b1;
            w.entry0 = make_entry(k0);
        end
        if (n >= 2) begin
            w.valid1 = 1'b1;
            w.entry1 = make_entry(k1);
        end
        return w;
    endfunction

    // expected outputs from the model state
    function automatic expect_t expected_outputs();
        expect_t e;
        e = '0;
        if (m_hold) begin
            e.rd.valid0 = 1'b1;   // held entry goes out alone
            e.rd.entry0 = m_held;
        end else begin
            if (mq.size() >= 1) begin
                e.rd.valid0 = 1'b1;
                e.rd.entry0 = mq[0];
            end
            if (mq.size() >= 2) begin
                e.rd.valid1 = 1'b1;
                e.rd.entry1 = mq[1];
            end
        end
        e.full = (mq.size() >= FULL_LEVEL);
        e.ids  = m_ids;
        return e;
    endfunction

    task automatic check(input string what, input logic [131:0] got, input logic [131:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic to_drive_point();
        @(posedge clk);
        #2;
    endtask

    task automatic set_inputs(input iq_pkg::iq_wr_pkt_t w, input logic i0, input logic i1,
                              input logic fl, input logic ks);
        if (w.valid0 && full) begin
            errors++;
            $display("stimulus error at %0t: write attempted while full", $time);
        end
        wr_pkt    = w;
        issue0    = i0;
        issue1    = i1;
        flush     = fl;
        keep_slot = ks;
    endtask

    task automatic drive(input iq_pkg::iq_wr_pkt_t w, input logic i0, input logic i1,
                         input logic fl, input logic ks);
        to_drive_point();
        set_inputs(w, i0, i1, fl, ks);
    endtask

    task automatic idle(input int n);
        repeat (n) drive('0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic apply_reset();
        fifo_rst = 1'b1;
        set_inputs('0, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (10) @(posedge clk);
        #2;
        fifo_rst = 1'b0;
    endtask

    // issue both slots until the DUT shows nothing at the head
    task automatic drain_queue();
        int n;
        n = 0;
        idle(1);
        while (rd_pkt.valid0 && n < DRAIN_LIMIT) begin
            drive('0, 1'b1, 1'b1, 1'b0, 1'b0);
            n++;
        end
        if (rd_pkt.valid0) begin
            timeouts++;
            $display("timeout: queue still not empty after %0d drain cycles", DRAIN_LIMIT);
        end
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        iq_pkg::iq_wr_pkt_t w;
        to_drive_point();
        r = $random(seed);
        w = '0;
        if ((r[0] || r[3]) && mq.size() < FULL_LEVEL)
            w = pair_pkt(r[9] ? 2 : 1, int'(r[12:10]), int'(r[15:13]));
        set_inputs(w, r[1], r[1] && r[2], r[7:4] == 4'd0, r[8]);   // flush about 1 in 16
    endtask

    task automatic branch_case(input int k, input logic alone);
        drive(pair_pkt(2, k, K_ADD), 1'b0, 1'b0, 1'b0, 1'b0);
        drive('0, 1'b1, !alone, 1'b0, 1'b0);
        idle(2);   // flag must hold without a take
        @(negedge clk);
        check("in_delay_slot after branch issue", 132'(in_delay_slot), 132'(alone));
        drain_queue();
    endtask

    always @(posedge clk) begin : model_update
        expect_t e;
        logic    tk0;
        logic    tk1;
        logic    cap;
        e = expected_outputs();
        if (fifo_rst) begin
            mq.delete();
            m_hold = 1'b0;
            m_ids  = 1'b0;
            m_cnt0 = '0;
            m_cnt1 = '0;
        end else begin
            tk0 = issue0 && e.rd.valid0;
            tk1 = issue0 && issue1 && e.rd.valid1;
            cap = flush && keep_slot && !tk0 && e.rd.valid0;
            m_cnt0 = m_cnt0 + STAT_W'(tk0);
            m_cnt1 = m_cnt1 + STAT_W'(tk1);
            if (flush)
                m_ids = 1'b0;
            else if (tk0)
                m_ids = is_branch(e.rd.entry0.instr) && !tk1;
            if (cap)
                m_held = e.rd.entry0;
            if (flush) begin
                mq.delete();   // same-cycle write is lost
                m_hold = cap;
            end else begin
                if (m_hold && tk0) begin
                    m_hold = 1'b0;
                end else if (!m_hold) begin
                    if (tk0)
                        void'(mq.pop_front());
                    if (tk1)
                        void'(mq.pop_front());
                end
                if (wr_pkt.valid0)
                    mq.push_back(wr_pkt.entry0);
                if (wr_pkt.valid1)
                    mq.push_back(wr_pkt.entry1);
            end
        end
    end

    // outputs settle well before the falling edge
    initial begin : compare_outputs
        expect_t e;
        @(posedge clk);
        forever begin
            @(negedge clk);
            e = expected_outputs();
            check("rd_pkt", 132'(rd_pkt), 132'(e.rd));
            check("full", 132'(full), 132'(e.full));
            check("in_delay_slot", 132'(in_delay_slot), 132'(e.ids));
            check("stats.count0", 132'(stats.count0), 132'(m_cnt0));
            check("stats.count1", 132'(stats.count1), 132'(m_cnt1));
        end
    end

    initial begin : main
        fifo_rst = 1'b1;
        set_inputs('0, 1'b0, 1'b0, 1'b0, 1'b0);
        apply_reset();
        @(negedge clk);
        check("stats after reset", 132'(stats), 132'(0));

        drive(pair_pkt(1, K_ADD, K_ADD), 1'b0, 1'b0, 1'b0, 1'b0);
        drive(pair_pkt(2, K_LW, K_ADDI), 1'b0, 1'b0, 1'b0, 1'b0);
        drive(pair_pkt(2, K_ADD, K_LW), 1'b0, 1'b0, 1'b0, 1'b0);
        drive(pair_pkt(1, K_ADDI, K_ADD), 1'b1, 1'b0, 1'b0, 1'b0);
        drain_queue();

        for (int i = 0; i < 400; i++)
            random_cycle();
        drain_queue();

        branch_case(K_BEQ, 1'b1);
        branch_case(K_JR, 1'b1);
        branch_case(K_JALR, 1'b1);
        branch_case(K_REGIMM, 1'b1);
        branch_case(K_J, 1'b0);
        branch_case(K_JALR, 1'b0);

        // plain flush, the write beside it never lands
        drive(pair_pkt(2, K_ADD, K_LW), 1'b0, 1'b0, 1'b0, 1'b0);
        drive(pair_pkt(2, K_ADD, K_LW), 1'b0, 1'b0, 1'b1, 1'b0);
        idle(1);
        @(negedge clk);
        check("rd_pkt.valid0 after flush", 132'(rd_pkt.valid0), 132'(0));

        // flush keeping the head, new writes queue behind it
        drive(pair_pkt(2, K_BEQ, K_ADD), 1'b0, 1'b0, 1'b0, 1'b0);
        drive('0, 1'b0, 1'b0, 1'b1, 1'b1);
        drive(pair_pkt(2, K_LW, K_ADD), 1'b0, 1'b0, 1'b0, 1'b0);
        drive(pair_pkt(2, K_ADDI, K_ADD), 1'b0, 1'b0, 1'b0, 1'b0);
        idle(1);
        @(negedge clk);
        check("slot 1 while holding", 132'(rd_pkt.valid1), 132'(0));
        drive('0, 1'b1, 1'b1, 1'b0, 1'b0);   // issue1 has no effect here
        idle(1);
        @(negedge clk);
        check("queue behind held entry", 132'(rd_pkt.valid1), 132'(1));
        drain_queue();

        apply_reset();
        @(negedge clk);
        check("stats after second reset", 132'(stats), 132'(0));

        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
